//--- rtl/fetch_types_pkg.sv
package fetch_types_pkg;

    localparam int addr_width      = 32;
    localparam int btb_offset_bits = 2;
    localparam int btb_index_bits  = 4;
    localparam int btb_tag_bits    = addr_width - btb_index_bits - btb_offset_bits;

    // one fetch address word, read whole or split for the target buffer
    typedef union packed {
        logic [addr_width-1:0] raw;
        struct packed {
            logic [btb_tag_bits-1:0]    tag;
            logic [btb_index_bits-1:0]  index;
            logic [btb_offset_bits-1:0] offset;
        } btb;
    } fetch_addr_u;

    // target buffer line
    typedef struct packed {
        logic                    valid;
        logic [btb_tag_bits-1:0] tag;
        logic [addr_width-1:0]   target;
    } btb_entry_t;

endpackage

//--- rtl/predictor_state_pkg.sv
package predictor_state_pkg;

    // single-bit pattern entry
    typedef enum logic {
        not_taken = 1'b0,
        taken     = 1'b1
    } pht_state_e;

    localparam int bias_width = 2;

    // saturation limits of the chooser counter
    localparam logic [bias_width-1:0] bias_min = 2'b00;
    localparam logic [bias_width-1:0] bias_max = 2'b11;

    // fully biased toward the local predictor
    localparam logic [bias_width-1:0] bias_reset_value = 2'b11;

endpackage

//--- rtl/branch_target_buffer.sv
`timescale 1ns/1ns

module branch_target_buffer #(
    parameter int fetch_width = 2
) (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  fetch_types_pkg::fetch_addr_u [fetch_width-1:0]          lookup_pc,
    output logic [fetch_width-1:0]                                  hit,
    output logic [fetch_width-1:0][fetch_types_pkg::addr_width-1:0] target,
    input  logic [fetch_width-1:0]                                  resolve_valid,
    input  logic [fetch_width-1:0]                                  resolve_taken,
    input  fetch_types_pkg::fetch_addr_u [fetch_width-1:0]          resolve_pc,
    input  logic [fetch_width-1:0][fetch_types_pkg::addr_width-1:0] resolve_target
);

    import fetch_types_pkg::*;

    localparam int depth = 1 << btb_index_bits;

    btb_entry_t entries      [depth];
    btb_entry_t entries_next [depth];

    // lookup, one read port per slot
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            hit[i]    = entries[lookup_pc[i].btb.index].valid &&
                        (entries[lookup_pc[i].btb.index].tag == lookup_pc[i].btb.tag);
            target[i] = entries[lookup_pc[i].btb.index].target;
        end
    end

    // slot order, so a later slot overwrites an earlier one on the same line
    always_comb begin
        entries_next = entries;
        for (int i = 0; i < fetch_width; i++) begin
            if (resolve_valid[i] && resolve_taken[i]) begin
                entries_next[resolve_pc[i].btb.index].valid  = 1'b1;
                entries_next[resolve_pc[i].btb.index].tag    = resolve_pc[i].btb.tag;
                entries_next[resolve_pc[i].btb.index].target = resolve_target[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                entries[i] <= '0;
            end
        end else begin
            entries <= entries_next;
        end
    end

    // commit must never hand over a floating strobe
    assert property (@(posedge clock) disable iff (reset) !$isunknown(resolve_valid))
        else $error("resolve_valid carries unknown bits after reset");

endmodule

//--- rtl/local_predictor.sv
`timescale 1ns/1ns

module local_predictor #(
    parameter int fetch_width        = 2,
    parameter int local_history_bits = 4,
    parameter int local_table_bits   = 5
) (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  fetch_types_pkg::fetch_addr_u                            pc_start,
    input  logic [fetch_width-1:0]                                  resolve_valid,
    input  logic [fetch_width-1:0]                                  resolve_taken,
    input  fetch_types_pkg::fetch_addr_u [fetch_width-1:0]          resolve_pc,
    input  logic [fetch_width-1:0][fetch_types_pkg::addr_width-1:0] resolve_target,
    output logic [fetch_width-1:0]                                  pred_taken,
    output logic [fetch_width-1:0][fetch_types_pkg::addr_width-1:0] pred_next_pc,
    output logic [fetch_width-1:0]                                  correct
);

    import fetch_types_pkg::*;
    import predictor_state_pkg::*;

    localparam int history_depth = 1 << local_table_bits;
    localparam int pattern_depth = 1 << local_history_bits;

    logic [local_history_bits-1:0] history      [history_depth];
    logic [local_history_bits-1:0] history_next [history_depth];
    pht_state_e                    pattern      [pattern_depth];
    pht_state_e                    pattern_next [pattern_depth];

    fetch_addr_u [fetch_width-1:0]                       slot_pc;
    logic        [fetch_width-1:0][local_table_bits-1:0] lookup_index;
    logic        [fetch_width-1:0][local_table_bits-1:0] resolve_index;
    logic        [fetch_width-1:0]                       pattern_taken;
    logic        [fetch_width-1:0]                       btb_hit;
    logic        [fetch_width-1:0][addr_width-1:0]       btb_target;

    branch_target_buffer #(
        .fetch_width(fetch_width)
    ) btb (
        .clock         (clock),
        .reset         (reset),
        .lookup_pc     (slot_pc),
        .hit           (btb_hit),
        .target        (btb_target),
        .resolve_valid (resolve_valid),
        .resolve_taken (resolve_taken),
        .resolve_pc    (resolve_pc),
        .resolve_target(resolve_target)
    );

    for (genvar i = 0; i < fetch_width; i++) begin : g_slot
        // word index, byte offset dropped
        assign lookup_index[i]  = slot_pc[i].raw[local_table_bits+1:2];
        assign resolve_index[i] = resolve_pc[i].raw[local_table_bits+1:2];

        assign pattern_taken[i] = pattern[history[lookup_index[i]]] == taken;
        assign pred_taken[i]    = pattern_taken[i] && btb_hit[i];
        assign pred_next_pc[i]  = pred_taken[i] ? btb_target[i] : slot_pc[i].raw + addr_width'(4);

        assign correct[i] = (pattern[history[resolve_index[i]]] == taken) == resolve_taken[i];

        if (i == 0) begin : g_head
            assign slot_pc[i] = pc_start;
        end else begin : g_chain
            assign slot_pc[i].raw = pred_next_pc[i-1];
        end
    end

    // history shifts accumulate, pattern index uses the old history
    always_comb begin
        history_next = history;
        pattern_next = pattern;
        for (int i = 0; i < fetch_width; i++) begin
            if (resolve_valid[i]) begin
                history_next[resolve_index[i]] =
                    {history_next[resolve_index[i]][local_history_bits-2:0], resolve_taken[i]};
                pattern_next[history[resolve_index[i]]] = resolve_taken[i] ? taken : not_taken;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < history_depth; i++) begin
                history[i] <= '0;
            end
            // odd entries start taken
            for (int i = 0; i < pattern_depth; i++) begin
                pattern[i] <= i[0] ? taken : not_taken;
            end
        end else begin
            history <= history_next;
            pattern <= pattern_next;
        end
    end

endmodule

//--- rtl/gshare_predictor.sv
`timescale 1ns/1ns

module gshare_predictor #(
    parameter int fetch_width         = 2,
    parameter int gshare_history_bits = 4,
    parameter int gshare_index_bits   = 8
) (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  fetch_types_pkg::fetch_addr_u                            pc_start,
    input  logic [fetch_width-1:0]                                  resolve_valid,
    input  logic [fetch_width-1:0]                                  resolve_taken,
    input  fetch_types_pkg::fetch_addr_u [fetch_width-1:0]          resolve_pc,
    input  logic [fetch_width-1:0][fetch_types_pkg::addr_width-1:0] resolve_target,
    output logic [fetch_width-1:0]                                  pred_taken,
    output logic [fetch_width-1:0][fetch_types_pkg::addr_width-1:0] pred_next_pc,
    output logic [fetch_width-1:0]                                  correct
);

    import fetch_types_pkg::*;
    import predictor_state_pkg::*;

    localparam int pattern_depth = 1 << gshare_index_bits;

    logic [gshare_history_bits-1:0] global_history;
    logic [gshare_history_bits-1:0] global_history_next;
    pht_state_e                     pattern      [pattern_depth];
    pht_state_e                     pattern_next [pattern_depth];

    fetch_addr_u [fetch_width-1:0]                        slot_pc;
    logic        [fetch_width-1:0][gshare_index_bits-1:0] lookup_index;
    logic        [fetch_width-1:0][gshare_index_bits-1:0] resolve_index;
    logic        [fetch_width-1:0]                        pattern_taken;
    logic        [fetch_width-1:0]                        btb_hit;
    logic        [fetch_width-1:0][addr_width-1:0]        btb_target;

    // history folded into the top index bits
    function automatic logic [gshare_index_bits-1:0] fold_index(
        input logic [addr_width-1:0]          pc,
        input logic [gshare_history_bits-1:0] history
    );
        logic [gshare_index_bits-1:0] wide_history;
        wide_history = gshare_index_bits'(history);
        return pc[gshare_index_bits+1:2] ^
               (wide_history << (gshare_index_bits - gshare_history_bits));
    endfunction

    branch_target_buffer #(
        .fetch_width(fetch_width)
    ) btb (
        .clock         (clock),
        .reset         (reset),
        .lookup_pc     (slot_pc),
        .hit           (btb_hit),
        .target        (btb_target),
        .resolve_valid (resolve_valid),
        .resolve_taken (resolve_taken),
        .resolve_pc    (resolve_pc),
        .resolve_target(resolve_target)
    );

    for (genvar i = 0; i < fetch_width; i++) begin : g_slot
        assign lookup_index[i]  = fold_index(slot_pc[i].raw, global_history);
        assign resolve_index[i] = fold_index(resolve_pc[i].raw, global_history);

        assign pattern_taken[i] = pattern[lookup_index[i]] == taken;
        assign pred_taken[i]    = pattern_taken[i] && btb_hit[i];
        assign pred_next_pc[i]  = pred_taken[i] ? btb_target[i] : slot_pc[i].raw + addr_width'(4);

        assign correct[i] = (pattern[resolve_index[i]] == taken) == resolve_taken[i];

        if (i == 0) begin : g_head
            assign slot_pc[i] = pc_start;
        end else begin : g_chain
            assign slot_pc[i].raw = pred_next_pc[i-1];
        end
    end

    // every valid slot shifts in, all writes indexed with the old history
    always_comb begin
        global_history_next = global_history;
        pattern_next        = pattern;
        for (int i = 0; i < fetch_width; i++) begin
            if (resolve_valid[i]) begin
                global_history_next =
                    {global_history_next[gshare_history_bits-2:0], resolve_taken[i]};
                pattern_next[resolve_index[i]] = resolve_taken[i] ? taken : not_taken;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            global_history <= '0;
            for (int i = 0; i < pattern_depth; i++) begin
                pattern[i] <= not_taken;
            end
        end else begin
            global_history <= global_history_next;
            pattern        <= pattern_next;
        end
    end

endmodule

//--- rtl/predictor_chooser.sv
`timescale 1ns/1ns

module predictor_chooser #(
    parameter int fetch_width = 2
) (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic [fetch_width-1:0]                                  local_taken,
    input  logic [fetch_width-1:0][fetch_types_pkg::addr_width-1:0] local_next_pc,
    input  logic [fetch_width-1:0]                                  global_taken,
    input  logic [fetch_width-1:0][fetch_types_pkg::addr_width-1:0] global_next_pc,
    input  logic [fetch_width-1:0]                                  local_correct,
    input  logic [fetch_width-1:0]                                  global_correct,
    input  logic [fetch_width-1:0]                                  resolve_valid,
    output logic [fetch_width-1:0]                                  pred_taken,
    output logic [fetch_width-1:0][fetch_types_pkg::addr_width-1:0] pred_next_pc
);

    import predictor_state_pkg::*;

    logic [bias_width-1:0] bias;
    logic [bias_width-1:0] bias_next;

    // only disagreements move the counter
    always_comb begin
        bias_next = bias;
        for (int i = 0; i < fetch_width; i++) begin
            if (resolve_valid[i]) begin
                if (local_correct[i] && !global_correct[i] && bias_next != bias_max) begin
                    bias_next = bias_next + 1'b1;
                end else if (global_correct[i] && !local_correct[i] &&
                             bias_next != bias_min) begin
                    bias_next = bias_next - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bias <= bias_reset_value;
        end else begin
            bias <= bias_next;
        end
    end

    // upper half of the counter means local
    assign pred_taken   = bias[bias_width-1] ? local_taken : global_taken;
    assign pred_next_pc = bias[bias_width-1] ? local_next_pc : global_next_pc;

    // at most one step per resolved slot
    assert property (@(posedge clock) disable iff (reset)
        !$past(reset) |->
            ((bias >= $past(bias)) ? (bias - $past(bias)) : ($past(bias) - bias))
                <= fetch_width)
        else $error("bias moved more than %0d steps in one cycle", fetch_width);

endmodule

//--- rtl/tournament_predictor.sv
`timescale 1ns/1ns

module tournament_predictor #(
    parameter int fetch_width         = 2,
    parameter int local_history_bits  = 4,
    parameter int local_table_bits    = 5,
    parameter int gshare_index_bits   = 8,
    parameter int gshare_history_bits = 4
) (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  fetch_types_pkg::fetch_addr_u                            pc_start,
    input  logic [fetch_width-1:0]                                  resolve_valid,
    input  logic [fetch_width-1:0]                                  resolve_taken,
    input  fetch_types_pkg::fetch_addr_u [fetch_width-1:0]          resolve_pc,
    input  logic [fetch_width-1:0][fetch_types_pkg::addr_width-1:0] resolve_target,
    output logic [fetch_width-1:0]                                  pred_taken,
    output logic [fetch_width-1:0][fetch_types_pkg::addr_width-1:0] pred_next_pc
);

    logic [fetch_width-1:0]                                  lp_taken;
    logic [fetch_width-1:0][fetch_types_pkg::addr_width-1:0] lp_next_pc;
    logic [fetch_width-1:0]                                  lp_correct;
    logic [fetch_width-1:0]                                  gp_taken;
    logic [fetch_width-1:0][fetch_types_pkg::addr_width-1:0] gp_next_pc;
    logic [fetch_width-1:0]                                  gp_correct;

    local_predictor #(
        .fetch_width       (fetch_width),
        .local_history_bits(local_history_bits),
        .local_table_bits  (local_table_bits)
    ) lp (
        .clock         (clock),
        .reset         (reset),
        .pc_start      (pc_start),
        .resolve_valid (resolve_valid),
        .resolve_taken (resolve_taken),
        .resolve_pc    (resolve_pc),
        .resolve_target(resolve_target),
        .pred_taken    (lp_taken),
        .pred_next_pc  (lp_next_pc),
        .correct       (lp_correct)
    );

    gshare_predictor #(
        .fetch_width        (fetch_width),
        .gshare_history_bits(gshare_history_bits),
        .gshare_index_bits  (gshare_index_bits)
    ) gp (
        .clock         (clock),
        .reset         (reset),
        .pc_start      (pc_start),
        .resolve_valid (resolve_valid),
        .resolve_taken (resolve_taken),
        .resolve_pc    (resolve_pc),
        .resolve_target(resolve_target),
        .pred_taken    (gp_taken),
        .pred_next_pc  (gp_next_pc),
        .correct       (gp_correct)
    );

    predictor_chooser #(
        .fetch_width(fetch_width)
    ) chooser (
        .clock         (clock),
        .reset         (reset),
        .local_taken   (lp_taken),
        .local_next_pc (lp_next_pc),
        .global_taken  (gp_taken),
        .global_next_pc(gp_next_pc),
        .local_correct (lp_correct),
        .global_correct(gp_correct),
        .resolve_valid (resolve_valid),
        .pred_taken    (pred_taken),
        .pred_next_pc  (pred_next_pc)
    );

endmodule

//--- verification/predictor_model.svh
`ifndef predictor_model_svh
`define predictor_model_svh

// reference state, one set of tables per predictor
logic [local_history_bits-1:0]  m_hist [1 << local_table_bits];
pht_state_e                     m_lpat [1 << local_history_bits];
logic [gshare_history_bits-1:0] m_ghist;
pht_state_e                     m_gpat [1 << gshare_index_bits];
btb_entry_t                     m_lbtb [1 << btb_index_bits];
btb_entry_t                     m_gbtb [1 << btb_index_bits];
logic [1:0]                     m_bias;

function automatic logic [local_table_bits-1:0] local_row(input logic [addr_width-1:0] pc);
    return pc[2 +: local_table_bits];
endfunction

// history lands on the top bits of the word index
function automatic logic [gshare_index_bits-1:0] gshare_row(
    input logic [addr_width-1:0]          pc,
    input logic [gshare_history_bits-1:0] hist
);
    logic [gshare_index_bits-1:0] row;
    row = pc[2 +: gshare_index_bits];
    row[gshare_index_bits-1 -: gshare_history_bits] = 
        row[gshare_index_bits-1 -: gshare_history_bits] ^ hist;
    return row;
endfunction

function automatic void model_reset();
    foreach (m_hist[i]) begin
        m_hist[i] = '0;
    end
    foreach (m_lpat[i]) begin
        m_lpat[i] = (i % 2 == 1) ? taken : not_taken;
    end
    foreach (m_gpat[i]) begin
        m_gpat[i] = not_taken;
    end
    foreach (m_lbtb[i]) begin
        m_lbtb[i] = '0;
        m_gbtb[i] = '0;
    end
    m_ghist = '0;
    m_bias  = bias_reset_value;
endfunction

// slot i+1 starts where slot i is predicted to go
function automatic void model_chain(
    input  bit                                     use_local,
    input  logic [addr_width-1:0]                  start,
    output logic [fetch_width-1:0]                 taken_v,
    output logic [fetch_width-1:0][addr_width-1:0] next_v
);
    fetch_addr_u pc;
    btb_entry_t  line;
    logic        dir;
    pc.raw = start;
    for (int i = 0; i < fetch_width; i++) begin
        if (use_local) begin
            dir  = m_lpat[m_hist[local_row(pc.raw)]] == taken;
            line = m_lbtb[pc.btb.index];
        end else begin
            dir  = m_gpat[gshare_row(pc.raw, m_ghist)] == taken;
            line = m_gbtb[pc.btb.index];
        end
        taken_v[i] = dir && line.valid && (line.tag == pc.btb.tag);
        next_v[i]  = taken_v[i] ? line.target : pc.raw + 32'd4;
        pc.raw     = next_v[i];
    end
endfunction

function automatic void model_train(
    input logic [fetch_width-1:0]                 v,
    input logic [fetch_width-1:0]                 t,
    input logic [fetch_width-1:0][addr_width-1:0] rpc,
    input logic [fetch_width-1:0][addr_width-1:0] tgt
);
    logic [local_history_bits-1:0]  hist_n [1 << local_table_bits];
    pht_state_e                     lpat_n [1 << local_history_bits];
    pht_state_e                     gpat_n [1 << gshare_index_bits];
    logic [gshare_history_bits-1:0] ghist_n;
    fetch_addr_u                    pc;
    btb_entry_t                     line;
    logic                           l_ok;
    logic                           g_ok;
    hist_n  = m_hist;
    lpat_n  = m_lpat;
    gpat_n  = m_gpat;
    ghist_n = m_ghist;
    for (int i = 0; i < fetch_width; i++) begin
        if (v[i]) begin
            pc.raw = rpc[i];
            // judged on the state before this edge
            l_ok = (m_lpat[m_hist[local_row(pc.raw)]] == taken) == t[i];
            g_ok = (m_gpat[gshare_row(pc.raw, m_ghist)] == taken) == t[i];
            if (l_ok && !g_ok && m_bias != 2'd3) begin
                m_bias = m_bias + 2'd1;
            end else if (g_ok && !l_ok && m_bias != 2'd0) begin
                m_bias = m_bias - 2'd1;
            end
            hist_n[local_row(pc.raw)] =
                {hist_n[local_row(pc.raw)][local_history_bits-2:0], t[i]};
            lpat_n[m_hist[local_row(pc.raw)]]   = pht_state_e'(t[i]);
            gpat_n[gshare_row(pc.raw, m_ghist)] = pht_state_e'(t[i]);
            ghist_n = {ghist_n[gshare_history_bits-2:0], t[i]};
            if (t[i]) begin
                line.valid  = 1'b1;
                line.tag    = pc.btb.tag;
                line.target = tgt[i];
                m_lbtb[pc.btb.index] = line;
                m_gbtb[pc.btb.index] = line;
            end
        end
    end
    m_hist  = hist_n;
    m_lpat  = lpat_n;
    m_gpat  = gpat_n;
    m_ghist = ghist_n;
endfunction

`endif

//--- verification/tournament_predictor_tb.sv
`timescale 1ns/1ns

module tournament_predictor_tb;

    import fetch_types_pkg::*;
    import predictor_state_pkg::*;

    localparam int fetch_width         = 2;
    localparam int local_history_bits  = 4;
    localparam int local_table_bits    = 5;
    localparam int gshare_index_bits   = 8;
    localparam int gshare_history_bits = 4;

    logic                                   clock;
    logic                                   reset;
    fetch_addr_u                            pc_start;
    logic [fetch_width-1:0]                 resolve_valid;
    logic [fetch_width-1:0]                 resolve_taken;
    fetch_addr_u [fetch_width-1:0]          resolve_pc;
    logic [fetch_width-1:0][addr_width-1:0] resolve_target;
    logic [fetch_width-1:0]                 pred_taken;
    logic [fetch_width-1:0][addr_width-1:0] pred_next_pc;

    int mismatches;
    int test_mismatches;
    int tests_run;
    int tests_failed;

    `include "predictor_model.svh"

    tournament_predictor #(
        .fetch_width        (fetch_width),
        .local_history_bits (local_history_bits),
        .local_table_bits   (local_table_bits),
        .gshare_index_bits  (gshare_index_bits),
        .gshare_history_bits(gshare_history_bits)
    ) dut (
        .clock         (clock),
        .reset         (reset),
        .pc_start      (pc_start),
        .resolve_valid (resolve_valid),
        .resolve_taken (resolve_taken),
        .resolve_pc    (resolve_pc),
        .resolve_target(resolve_target),
        .pred_taken    (pred_taken),
        .pred_next_pc  (pred_next_pc)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // model follows the same edges as the DUT
    always @(posedge clock) begin
        if (reset) begin
            model_reset();
        end else begin
            model_train(resolve_valid, resolve_taken, resolve_pc, resolve_target);
        end
    end

    task automatic check_value(input string name, input logic [addr_width-1:0] expected,
                               input logic [addr_width-1:0] actual);
        if (expected !== actual) begin
            $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            test_mismatches++;
        end
    endtask

    task automatic check_outputs();
        logic [fetch_width-1:0]                 exp_taken;
        logic [fetch_width-1:0][addr_width-1:0] exp_next;
        model_chain(m_bias[1], pc_start.raw, exp_taken, exp_next);
        for (int i = 0; i < fetch_width; i++) begin
            check_value($sformatf("pred_taken[%0d]", i), exp_taken[i], pred_taken[i]);
            check_value($sformatf("pred_next_pc[%0d]", i), exp_next[i], pred_next_pc[i]);
        end
    endtask

    // inputs change on the falling edge, outputs read a little later
    task automatic apply_cycle(input logic [addr_width-1:0] pc, input logic [fetch_width-1:0] v,
                               input logic [fetch_width-1:0] t,
                               input logic [fetch_width-1:0][addr_width-1:0] rpc,
                               input logic [fetch_width-1:0][addr_width-1:0] tgt);
        @(negedge clock);
        pc_start.raw   = pc;
        resolve_valid  = v;
        resolve_taken  = t;
        resolve_pc     = rpc;
        resolve_target = tgt;
        #1;
        check_outputs();
    endtask

    task automatic apply_reset();
        @(negedge clock);
        reset         = 1'b1;
        resolve_valid = '0;
        repeat (16) @(negedge clock);
        reset = 1'b0;
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run++;
        if (test_mismatches == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d mismatches", num, name, test_mismatches);
            tests_failed++;
        end
        mismatches      = mismatches + test_mismatches;
        test_mismatches = 0;
    endtask

    initial begin
        logic [addr_width-1:0]                  branch_pc;
        logic [addr_width-1:0]                  target_pc;
        logic [addr_width-1:0]                  pool [8];
        logic [fetch_width-1:0][addr_width-1:0] rpc;
        logic [fetch_width-1:0][addr_width-1:0] tgt;
        logic [fetch_width-1:0]                 exp_taken;
        logic [fetch_width-1:0][addr_width-1:0] exp_next;
        int                                     periods;
        void'($urandom(32'ha6f4));
        reset           = 1'b1;
        pc_start        = '0;
        resolve_valid   = '0;
        resolve_taken   = '0;
        resolve_pc      = '0;
        resolve_target  = '0;
        mismatches      = 0;
        test_mismatches = 0;
        tests_run       = 0;
        tests_failed    = 0;
        apply_reset();

        for (int n = 0; n < 8; n++) begin
            branch_pc = $urandom();
            apply_cycle(branch_pc, '0, '0, '0, '0);
            for (int i = 0; i < fetch_width; i++) begin
                check_value($sformatf("pred_taken[%0d]", i), 0, pred_taken[i]);
                check_value($sformatf("pred_next_pc[%0d]", i), branch_pc + 4 * (i + 1),
                            pred_next_pc[i]);
            end
        end
        finish_test(1, "reset chain");

        // target maps to another buffer line, so slot 1 falls through
        branch_pc = $urandom() & ~32'h3;
        target_pc = branch_pc + 32'h44;
        apply_cycle(branch_pc, 2'b01, 2'b01, {32'h0, branch_pc}, {32'h0, target_pc});
        apply_cycle(branch_pc, '0, '0, '0, '0);
        check_value("pred_taken[0]", 1, pred_taken[0]);
        check_value("pred_next_pc[0]", target_pc, pred_next_pc[0]);
        finish_test(2, "local training");
        check_value("pred_next_pc[1]", target_pc + 4, pred_next_pc[1]);
        finish_test(3, "slot chaining");

        // 0x100 and 0x280 alias in the local history table only
        apply_reset();
        periods = 0;
        while (m_bias >= 2 && periods < 40) begin
            apply_cycle(32'h100, 2'b01, 2'b01, {32'h0, 32'h100}, {32'h0, 32'h200});
            for (int k = 0; k < 5; k++) begin
                apply_cycle(32'h280, 2'b01, 2'b00, {32'h0, 32'h280}, '0);
            end
            periods++;
        end
        apply_cycle(32'h100, '0, '0, '0, '0);
        if (m_bias >= 2) begin
            $display("timeout: chooser bias still %0d after %0d periods", m_bias, periods);
            test_mismatches++;
        end
        model_chain(1'b0, 32'h100, exp_taken, exp_next);
        for (int i = 0; i < fetch_width; i++) begin
            check_value($sformatf("pred_taken[%0d]", i), exp_taken[i], pred_taken[i]);
            check_value($sformatf("pred_next_pc[%0d]", i), exp_next[i], pred_next_pc[i]);
        end
        finish_test(4, "chooser switch");

        // pairs k and k+4 share every index and differ in tag
        for (int k = 0; k < 8; k++) begin
            pool[k] = 32'h4000 + (k % 4) * 4 + (k / 4) * 32'h400;
        end
        for (int n = 0; n < 2000; n++) begin
            for (int i = 0; i < fetch_width; i++) begin
                rpc[i] = pool[$urandom_range(7)];
                tgt[i] = pool[$urandom_range(7)];
            end
            apply_cycle(pool[$urandom_range(7)], fetch_width'($urandom()),
                        fetch_width'($urandom()), rpc, tgt);
        end
        finish_test(5, "random traffic");

        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed,
                 mismatches);
        if (tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tournament_predictor.f
+incdir+verification
rtl/fetch_types_pkg.sv
rtl/predictor_state_pkg.sv
rtl/branch_target_buffer.sv
rtl/local_predictor.sv
rtl/gshare_predictor.sv
rtl/predictor_chooser.sv
rtl/tournament_predictor.sv
verification/tournament_predictor_tb.sv
